// ==== hdl/stream_pkg.sv ====
// Frame stream package with the beat format and frame length limits
`default_nettype none

package stream_pkg;

    // Largest frame kept by the frame FIFO, in bytes
    localparam int MAX_FRAME_LEN = 48;

    // Frame length counter, wide enough to reach MAX_FRAME_LEN
    localparam int LEN_W = $clog2(MAX_FRAME_LEN + 1);
    localparam logic [LEN_W-1:0] LEN_MAX = LEN_W'(MAX_FRAME_LEN);

    // Good-frame count shown on the LEDs
    localparam int CNT_W = 5;

    // One byte of a frame with its framing flags
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       bad;   // only meaningful on the last beat
    } beat_t;

endpackage

`default_nettype wire

// ==== hdl/port_ctrl_pkg.sv ====
// Port control package with UART and GMII transmit state encodings
`default_nettype none

package port_ctrl_pkg;

    // UART bit period input, in clk cycles
    localparam int PRESCALE_W = 16;

    // Minimum idle cycles on tx_en between frames
    localparam int IFG_CYCLES = 12;
    localparam int IFG_W = $clog2(IFG_CYCLES);
    localparam logic [IFG_W-1:0] GAP_LOAD = IFG_W'(IFG_CYCLES - 1);

    // Shared by the UART receiver and transmitter
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SEND,
        TX_GAP
    } tx_state_t;

endpackage

`default_nettype wire

// ==== hdl/uart_rx.sv ====
// UART receiver, samples rxd into bytes and flags bad stop bits
`default_nettype none

module uart_rx (
    input  wire logic                                 clk,
    input  wire logic                                 rst,
    input  wire logic                                 rxd,
    input  wire logic [port_ctrl_pkg::PRESCALE_W-1:0] prescale,
    input  wire logic                                 rx_ready,
    output logic      [7:0]                           rx_byte,
    output logic                                      rx_valid,
    output logic                                      frame_error
);

port_ctrl_pkg::uart_state_t state;
logic [port_ctrl_pkg::PRESCALE_W-1:0] cnt;
logic [2:0] bit_cnt;
logic [7:0] shreg;
logic bit_tick;
logic byte_done;

// Two-flop synchronizer, third stage for start edge detection
logic rxd_meta;
logic rxd_sync;
logic rxd_last;

assign bit_tick = (cnt == '0);

// Byte is dropped if the previous one is still waiting
assign byte_done = (state == port_ctrl_pkg::UART_STOP) && bit_tick && rxd_sync
    && (!rx_valid || rx_ready);

always_ff @(posedge clk) begin
    if (rst) begin
        rxd_meta <= 1'b1;
        rxd_sync <= 1'b1;
        rxd_last <= 1'b1;
    end else begin
        rxd_meta <= rxd;
        rxd_sync <= rxd_meta;
        rxd_last <= rxd_sync;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        state       <= port_ctrl_pkg::UART_IDLE;
        cnt         <= '0;
        bit_cnt     <= '0;
        rx_valid    <= 1'b0;
        frame_error <= 1'b0;
    end else begin
        if (rx_valid && rx_ready) begin
            rx_valid <= 1'b0;
        end
        case (state)
            port_ctrl_pkg::UART_IDLE: begin
                // Falling edge, then wait half a bit to reach its middle
                if (rxd_last && !rxd_sync) begin
                    cnt   <= (prescale >> 1) - 1'b1;
                    state <= port_ctrl_pkg::UART_START;
                end
            end
            port_ctrl_pkg::UART_START: begin
                if (!bit_tick) begin
                    cnt <= cnt - 1'b1;
                end else if (rxd_sync) begin
                    // Line went back high, treat as a glitch
                    state <= port_ctrl_pkg::UART_IDLE;
                end else begin
                    cnt     <= prescale - 1'b1;
                    bit_cnt <= '0;
                    state   <= port_ctrl_pkg::UART_DATA;
                end
            end
            port_ctrl_pkg::UART_DATA: begin
                if (!bit_tick) begin
                    cnt <= cnt - 1'b1;
                end else begin
                    cnt     <= prescale - 1'b1;
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) begin
                        state <= port_ctrl_pkg::UART_STOP;
                    end
                end
            end
            port_ctrl_pkg::UART_STOP: begin
                if (!bit_tick) begin
                    cnt <= cnt - 1'b1;
                end else begin
                    state <= port_ctrl_pkg::UART_IDLE;
                    if (!rxd_sync) begin
                        frame_error <= 1'b1;
                    end
                    if (byte_done) begin
                        rx_valid <= 1'b1;
                    end
                end
            end
            default: state <= port_ctrl_pkg::UART_IDLE;
        endcase
    end
end

// LSB first, so shift in from the top
always_ff @(posedge clk) begin
    if (state == port_ctrl_pkg::UART_DATA && bit_tick) begin
        shreg <= {rxd_sync, shreg[7:1]};
    end
    if (byte_done) begin
        rx_byte <= shreg;
    end
end

// Held byte stays put until the transmitter takes it
a_hold_byte: assert property (@(posedge clk) disable iff (rst)
    rx_valid && !rx_ready |=> rx_valid && $stable(rx_byte));

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
// UART transmitter, serializes accepted bytes onto txd as 8N1
`default_nettype none

module uart_tx (
    input  wire logic                                 clk,
    input  wire logic                                 rst,
    input  wire logic [port_ctrl_pkg::PRESCALE_W-1:0] prescale,
    input  wire logic [7:0]                           rx_byte,
    input  wire logic                                 rx_valid,
    output wire logic                                 rx_ready,
    output logic                                      txd
);

port_ctrl_pkg::uart_state_t state;
logic [port_ctrl_pkg::PRESCALE_W-1:0] cnt;
logic [2:0] bit_cnt;
logic [7:0] shreg;
logic bit_tick;

assign bit_tick = (cnt == '0);
assign rx_ready = (state == port_ctrl_pkg::UART_IDLE);

always_ff @(posedge clk) begin
    if (rst) begin
        state   <= port_ctrl_pkg::UART_IDLE;
        cnt     <= '0;
        bit_cnt <= '0;
        txd     <= 1'b1;
    end else begin
        case (state)
            port_ctrl_pkg::UART_IDLE: begin
                if (rx_valid) begin
                    txd   <= 1'b0;
                    cnt   <= prescale - 1'b1;
                    state <= port_ctrl_pkg::UART_START;
                end
            end
            port_ctrl_pkg::UART_START: begin
                if (!bit_tick) begin
                    cnt <= cnt - 1'b1;
                end else begin
                    txd     <= shreg[0];
                    cnt     <= prescale - 1'b1;
                    bit_cnt <= '0;
                    state   <= port_ctrl_pkg::UART_DATA;
                end
            end
            port_ctrl_pkg::UART_DATA: begin
                if (!bit_tick) begin
                    cnt <= cnt - 1'b1;
                end else begin
                    cnt     <= prescale - 1'b1;
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) begin
                        txd   <= 1'b1;
                        state <= port_ctrl_pkg::UART_STOP;
                    end else begin
                        txd <= shreg[0];
                    end
                end
            end
            port_ctrl_pkg::UART_STOP: begin
                if (!bit_tick) begin
                    cnt <= cnt - 1'b1;
                end else begin
                    state <= port_ctrl_pkg::UART_IDLE;
                end
            end
            default: state <= port_ctrl_pkg::UART_IDLE;
        endcase
    end
end

// Load on accept, shift after each bit goes out
always_ff @(posedge clk) begin
    if (rx_valid && rx_ready) begin
        shreg <= rx_byte;
    end else if (bit_tick && (state == port_ctrl_pkg::UART_START
                              || state == port_ctrl_pkg::UART_DATA)) begin
        shreg <= shreg >> 1;
    end
end

a_idle_high: assert property (@(posedge clk) disable iff (rst)
    state == port_ctrl_pkg::UART_IDLE |-> txd);

endmodule

`default_nettype wire

// ==== hdl/gmii_rx_adapter.sv ====
// GMII receive adapter, turns rxd/rx_dv/rx_er into framed stream beats
`default_nettype none

module gmii_rx_adapter (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic [7:0] gmii_rxd,
    input  wire logic       gmii_rx_dv,
    input  wire logic       gmii_rx_er,
    output stream_pkg::beat_t in_beat,
    output wire logic       in_valid
);

// One byte held back so the end of dv can mark it last
logic [7:0] data_q;
logic dv_q;

// rx_er seen on any byte of the frame so far, including data_q
logic err_q;

always_ff @(posedge clk) begin
    data_q <= gmii_rxd;
end

always_ff @(posedge clk) begin
    if (rst) begin
        dv_q  <= 1'b0;
        err_q <= 1'b0;
    end else begin
        dv_q  <= gmii_rx_dv;
        err_q <= gmii_rx_dv && (gmii_rx_er || (dv_q && err_q));
    end
end

assign in_valid = dv_q;

always_comb begin
    in_beat.data = data_q;
    in_beat.last = dv_q && !gmii_rx_dv;
    in_beat.bad  = dv_q && !gmii_rx_dv && err_q;
end

endmodule

`default_nettype wire

// ==== hdl/frame_fifo.sv ====
// Store-and-forward frame FIFO, drops bad, oversize and overflowing frames
`default_nettype none

module frame_fifo #(
    parameter int DEPTH = 64
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire stream_pkg::beat_t             in_beat,
    input  wire logic                          in_valid,
    input  wire logic                          out_ready,
    output stream_pkg::beat_t                  out_beat,
    output wire logic                          out_valid,
    output logic                               drop_bad,
    output logic                               drop_len,
    output logic [stream_pkg::CNT_W-1:0]       good_count
);

localparam int AW = $clog2(DEPTH);

stream_pkg::beat_t mem [DEPTH];

// Pointers carry one extra bit to tell full from empty
logic [AW:0] wr_ptr;
logic [AW:0] wr_commit;
logic [AW:0] rd_ptr;
logic [AW:0] committed;
logic [stream_pkg::LEN_W-1:0] len;
logic dropping;
logic full;
logic accept;

assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

// Once a beat is refused the rest of that frame is refused too
assign accept = in_valid && !dropping && !full && (len < stream_pkg::LEN_MAX);

always_ff @(posedge clk) begin
    if (accept) begin
        mem[wr_ptr[AW-1:0]] <= in_beat;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        wr_ptr     <= '0;
        wr_commit  <= '0;
        len        <= '0;
        dropping   <= 1'b0;
        drop_bad   <= 1'b0;
        drop_len   <= 1'b0;
        good_count <= '0;
    end else if (in_valid) begin
        if (in_beat.last) begin
            len      <= '0;
            dropping <= 1'b0;
            if (in_beat.bad) begin
                wr_ptr   <= wr_commit;
                drop_bad <= 1'b1;
            end else if (!accept) begin
                // Too long or out of room
                wr_ptr   <= wr_commit;
                drop_len <= 1'b1;
            end else begin
                wr_ptr     <= wr_ptr + 1'b1;
                wr_commit  <= wr_ptr + 1'b1;
                good_count <= good_count + 1'b1;
            end
        end else if (accept) begin
            wr_ptr <= wr_ptr + 1'b1;
            len    <= len + 1'b1;
        end else begin
            dropping <= 1'b1;
        end
    end
end

// Only committed frames are visible to the reader
assign committed = wr_commit - rd_ptr;
assign out_valid = (committed != '0);
assign out_beat  = mem[rd_ptr[AW-1:0]];

always_ff @(posedge clk) begin
    if (rst) begin
        rd_ptr <= '0;
    end else if (out_valid && out_ready) begin
        rd_ptr <= rd_ptr + 1'b1;
    end
end

// A read past the commit point would wrap this difference
a_rd_behind_commit: assert property (@(posedge clk) disable iff (rst)
    committed <= (AW + 1)'(DEPTH));

endmodule

`default_nettype wire

// ==== hdl/gmii_tx_framer.sv ====
// GMII transmit framer, sends whole frames and enforces the inter-frame gap
`default_nettype none

module gmii_tx_framer (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire stream_pkg::beat_t out_beat,
    input  wire logic              out_valid,
    output wire logic              out_ready,
    output logic [7:0]             gmii_txd,
    output logic                   gmii_tx_en
);

port_ctrl_pkg::tx_state_t state;
logic [port_ctrl_pkg::IFG_W-1:0] gap_cnt;

// Only the gap holds off the FIFO
assign out_ready = (state != port_ctrl_pkg::TX_GAP);

always_ff @(posedge clk) begin
    if (rst) begin
        state      <= port_ctrl_pkg::TX_IDLE;
        gap_cnt    <= '0;
        gmii_tx_en <= 1'b0;
    end else begin
        case (state)
            port_ctrl_pkg::TX_IDLE, port_ctrl_pkg::TX_SEND: begin
                gmii_tx_en <= out_valid;
                if (out_valid) begin
                    if (out_beat.last) begin
                        gap_cnt <= port_ctrl_pkg::GAP_LOAD;
                        state   <= port_ctrl_pkg::TX_GAP;
                    end else begin
                        state <= port_ctrl_pkg::TX_SEND;
                    end
                end
            end
            port_ctrl_pkg::TX_GAP: begin
                gmii_tx_en <= 1'b0;
                if (gap_cnt == '0) begin
                    state <= port_ctrl_pkg::TX_IDLE;
                end else begin
                    gap_cnt <= gap_cnt - 1'b1;
                end
            end
            default: state <= port_ctrl_pkg::TX_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    gmii_txd <= (out_valid && out_ready) ? out_beat.data : 8'h00;
end

// Whole frame is committed upstream, so it never runs dry mid-frame
a_no_holes: assert property (@(posedge clk) disable iff (rst)
    state == port_ctrl_pkg::TX_SEND |-> out_valid);

// First gap cycle still carries the last byte
a_gap_quiet: assert property (@(posedge clk) disable iff (rst)
    state == port_ctrl_pkg::TX_GAP && $past(state) == port_ctrl_pkg::TX_GAP
    |-> !gmii_tx_en);

endmodule

`default_nettype wire

// ==== hdl/fpga_core.sv ====
// FPGA core with UART echo, GMII frame loopback and status LEDs
`default_nettype none

module fpga_core (
    input  wire logic                                 clk,
    input  wire logic                                 rst,

    // UART, 8N1 at clk / prescale
    input  wire logic                                 uart_rxd,
    output wire logic                                 uart_txd,
    input  wire logic [port_ctrl_pkg::PRESCALE_W-1:0] prescale,

    // GMII, clock enable tied on
    input  wire logic [7:0]                           gmii_rxd,
    input  wire logic                                 gmii_rx_dv,
    input  wire logic                                 gmii_rx_er,
    output wire logic [7:0]                           gmii_txd,
    output wire logic                                 gmii_tx_en,

    output wire logic [7:0]                           led
);

// UART echo
logic [7:0] rx_byte;
logic rx_valid;
logic rx_ready;
logic frame_error;

uart_rx uart_rx_inst (
    .clk(clk),
    .rst(rst),
    .rxd(uart_rxd),
    .prescale(prescale),
    .rx_ready(rx_ready),
    .rx_byte(rx_byte),
    .rx_valid(rx_valid),
    .frame_error(frame_error)
);

uart_tx uart_tx_inst (
    .clk(clk),
    .rst(rst),
    .prescale(prescale),
    .rx_byte(rx_byte),
    .rx_valid(rx_valid),
    .rx_ready(rx_ready),
    .txd(uart_txd)
);

// Ethernet loopback through the frame FIFO
stream_pkg::beat_t in_beat;
stream_pkg::beat_t out_beat;
logic in_valid;
logic out_valid;
logic out_ready;
logic drop_bad;
logic drop_len;
logic [stream_pkg::CNT_W-1:0] good_count;

gmii_rx_adapter gmii_rx_inst (
    .clk(clk),
    .rst(rst),
    .gmii_rxd(gmii_rxd),
    .gmii_rx_dv(gmii_rx_dv),
    .gmii_rx_er(gmii_rx_er),
    .in_beat(in_beat),
    .in_valid(in_valid)
);

frame_fifo #(
    .DEPTH(64)
)
frame_fifo_inst (
    .clk(clk),
    .rst(rst),
    .in_beat(in_beat),
    .in_valid(in_valid),
    .out_ready(out_ready),
    .out_beat(out_beat),
    .out_valid(out_valid),
    .drop_bad(drop_bad),
    .drop_len(drop_len),
    .good_count(good_count)
);

gmii_tx_framer gmii_tx_inst (
    .clk(clk),
    .rst(rst),
    .out_beat(out_beat),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .gmii_txd(gmii_txd),
    .gmii_tx_en(gmii_tx_en)
);

assign led = {good_count, drop_len, drop_bad, frame_error};

endmodule

`default_nettype wire

// ==== sim/tb_fpga_core.sv ====
// Directed testbench for the FPGA core UART echo and GMII frame loopback
`default_nettype none

module tb_fpga_core;

localparam int BIT_CYCLES = 8;
localparam int BYTE_CYCLES = 10 * BIT_CYCLES;
localparam int FRAME_WAIT = 400;
// Far above 6 UART bytes and 6 frames of about 80 cycles each
localparam int TIMEOUT_CYCLES = 20000;

logic clk;
logic rst;
logic uart_rxd;
logic uart_txd;
logic [port_ctrl_pkg::PRESCALE_W-1:0] prescale;
logic [7:0] gmii_rxd;
logic gmii_rx_dv;
logic gmii_rx_er;
logic [7:0] gmii_txd;
logic gmii_tx_en;
logic [7:0] led;

integer seed = 93856;
int mismatches = 0;
int failures = 0;
int cycles = 0;

// Good frames sent so far
logic [stream_pkg::CNT_W-1:0] exp_count = '0;

// Stimulus and expected frames
logic [7:0] frame_buf[$];
logic [7:0] exp_bytes[$];
int exp_lens[$];

// Every tx_en burst, its length and the idle time before it
logic [7:0] tx_bytes[$];
int burst_len[$];
int idle_len[$];
int cur_len = 0;
int idle_cnt = 0;

fpga_core dut (
    .clk(clk),
    .rst(rst),
    .uart_rxd(uart_rxd),
    .uart_txd(uart_txd),
    .prescale(prescale),
    .gmii_rxd(gmii_rxd),
    .gmii_rx_dv(gmii_rx_dv),
    .gmii_rx_er(gmii_rx_er),
    .gmii_txd(gmii_txd),
    .gmii_tx_en(gmii_tx_en),
    .led(led)
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

initial begin
    while (cycles < TIMEOUT_CYCLES) begin
        @(posedge clk);
        cycles++;
    end
    failures++;
    $display("Error at time %0t: run did not end within %0d cycles", $time, TIMEOUT_CYCLES);
    $display("Mismatches: %0d, other errors: %0d", mismatches, failures);
    $display("Finished with errors");
    $finish;
end

// Outputs are registered, so the falling edge sees them settled
always @(negedge clk) begin
    if (rst) begin
        cur_len = 0;
        idle_cnt = 0;
    end else if (gmii_tx_en) begin
        if (cur_len == 0) begin
            idle_len.push_back(idle_cnt);
        end
        tx_bytes.push_back(gmii_txd);
        cur_len++;
        idle_cnt = 0;
    end else begin
        if (cur_len != 0) begin
            burst_len.push_back(cur_len);
        end
        cur_len = 0;
        idle_cnt++;
    end
end

task automatic report_mismatch(input string msg);
    mismatches++;
    $display("Mismatch at time %0t: %s", $time, msg);
endtask

task automatic report_failure(input string msg);
    failures++;
    $display("Error at time %0t: %s", $time, msg);
endtask

// Sends an 8N1 byte on rxd where a low stop_bit makes a framing error
task automatic send_uart(input logic [7:0] b, input logic stop_bit);
    int i;
    @(negedge clk);
    uart_rxd = 1'b0;
    repeat (BIT_CYCLES) @(negedge clk);
    for (i = 0; i < 8; i++) begin
        uart_rxd = b[i];
        repeat (BIT_CYCLES) @(negedge clk);
    end
    uart_rxd = stop_bit;
    repeat (BIT_CYCLES) @(negedge clk);
    uart_rxd = 1'b1;
endtask

// Finds a start bit on txd, then samples each bit near its middle
task automatic recv_uart(output logic [7:0] b, output logic ok);
    int n;
    int i;
    n = 0;
    b = '0;
    ok = 1'b0;
    @(negedge clk);
    while (uart_txd && n < 4 * BYTE_CYCLES) begin
        @(negedge clk);
        n++;
    end
    if (!uart_txd) begin
        repeat (BIT_CYCLES / 2) @(negedge clk);
        if (!uart_txd) begin
            for (i = 0; i < 8; i++) begin
                repeat (BIT_CYCLES) @(negedge clk);
                b[i] = uart_txd;
            end
            repeat (BIT_CYCLES) @(negedge clk);
            ok = uart_txd;
        end
    end
endtask

task automatic watch_txd_idle(input int n_cycles, output logic quiet);
    int n;
    quiet = 1'b1;
    for (n = 0; n < n_cycles; n++) begin
        @(negedge clk);
        if (!uart_txd) begin
            quiet = 1'b0;
        end
    end
endtask

task automatic make_frame(input int len);
    int i;
    frame_buf.delete();
    for (i = 0; i < len; i++) begin
        frame_buf.push_back(8'($random(seed)));
    end
endtask

task automatic expect_frame();
    foreach (frame_buf[i]) begin
        exp_bytes.push_back(frame_buf[i]);
    end
    exp_lens.push_back(frame_buf.size());
endtask

// er_idx marks the byte sent with rx_er and -1 means none
task automatic drive_frame(input int er_idx);
    int i;
    for (i = 0; i < frame_buf.size(); i++) begin
        @(negedge clk);
        gmii_rxd = frame_buf[i];
        gmii_rx_dv = 1'b1;
        gmii_rx_er = (i == er_idx);
    end
    @(negedge clk);
    gmii_rxd = 8'h00;
    gmii_rx_dv = 1'b0;
    gmii_rx_er = 1'b0;
endtask

task automatic wait_bursts(input int target);
    int n;
    n = 0;
    while (burst_len.size() < target && n < FRAME_WAIT) begin
        @(posedge clk);
        n++;
    end
    if (burst_len.size() < target) begin
        report_failure($sformatf("expected %0d tx_en bursts, only %0d came out",
            target, burst_len.size()));
    end
endtask

task automatic check_frames(input int byte_base, input int burst_base);
    int k;
    int i;
    for (k = 0; k < exp_lens.size(); k++) begin
        if (burst_base + k >= burst_len.size()) begin
            report_failure($sformatf("frame %0d never appeared on tx_en", k));
        end else if (burst_len[burst_base + k] != exp_lens[k]) begin
            report_mismatch($sformatf("tx_en burst %0d lasted %0d cycles, expected %0d",
                k, burst_len[burst_base + k], exp_lens[k]));
        end
    end
    for (i = 0; i < exp_bytes.size(); i++) begin
        if (byte_base + i >= tx_bytes.size()) begin
            report_failure("fewer bytes came out on txd than were sent");
            break;
        end
        if (tx_bytes[byte_base + i] !== exp_bytes[i]) begin
            report_mismatch($sformatf("txd byte %0d is %02h, expected %02h",
                i, tx_bytes[byte_base + i], exp_bytes[i]));
        end
    end
endtask

task automatic check_good_count();
    if (led[7:3] !== exp_count) begin
        report_mismatch($sformatf("good count %0d, expected %0d", led[7:3], exp_count));
    end
endtask

task automatic echo_uart_bytes();
    logic [7:0] b;
    logic [7:0] got;
    logic ok;
    int k;
    for (k = 0; k < 5; k++) begin
        b = 8'($random(seed));
        fork
            send_uart(b, 1'b1);
            recv_uart(got, ok);
        join
        if (!ok) begin
            report_failure($sformatf("UART byte %0d was not echoed on txd", k));
        end else if (got !== b) begin
            report_mismatch($sformatf("UART echo %0d is %02h, expected %02h", k, got, b));
        end
    end
    if (led[0] !== 1'b0) begin
        report_mismatch("led[0] set after clean UART bytes");
    end
endtask

task automatic flag_uart_stop_error();
    logic [7:0] b;
    logic quiet;
    b = 8'($random(seed));
    fork
        send_uart(b, 1'b0);
        watch_txd_idle(2 * BYTE_CYCLES, quiet);
    join
    if (!quiet) begin
        report_failure("a byte with a low stop bit was echoed on txd");
    end
    if (led[0] !== 1'b1) begin
        report_mismatch("led[0] not set after a low stop bit");
    end
endtask

task automatic loop_good_frame();
    int byte_base;
    int burst_base;
    byte_base = tx_bytes.size();
    burst_base = burst_len.size();
    exp_bytes.delete();
    exp_lens.delete();
    make_frame(20);
    expect_frame();
    drive_frame(-1);
    exp_count = exp_count + 1'b1;
    wait_bursts(burst_base + 1);
    check_frames(byte_base, burst_base);
    @(negedge clk);
    check_good_count();
endtask

task automatic reject_bad_frame();
    int burst_base;
    burst_base = burst_len.size();
    if (led[1] !== 1'b0) begin
        report_mismatch("led[1] set before any frame with rx_er");
    end
    make_frame(16);
    drive_frame(7);
    repeat (FRAME_WAIT / 2) @(posedge clk);
    if (burst_len.size() != burst_base || cur_len != 0) begin
        report_failure("a frame with rx_er was sent on tx_en");
    end
    @(negedge clk);
    if (led[1] !== 1'b1) begin
        report_mismatch("led[1] not set after a frame with rx_er");
    end
    check_good_count();
endtask

task automatic reject_oversize_frame();
    int byte_base;
    int burst_base;
    burst_base = burst_len.size();
    if (led[2] !== 1'b0) begin
        report_mismatch("led[2] set before any oversize frame");
    end
    make_frame(stream_pkg::MAX_FRAME_LEN + 1);
    drive_frame(-1);
    repeat (FRAME_WAIT / 2) @(posedge clk);
    if (burst_len.size() != burst_base || cur_len != 0) begin
        report_failure("an oversize frame was sent on tx_en");
    end
    @(negedge clk);
    if (led[2] !== 1'b1) begin
        report_mismatch("led[2] not set after an oversize frame");
    end
    check_good_count();

    // FIFO must still pass a normal frame after the drop
    byte_base = tx_bytes.size();
    exp_bytes.delete();
    exp_lens.delete();
    make_frame(30);
    expect_frame();
    drive_frame(-1);
    exp_count = exp_count + 1'b1;
    wait_bursts(burst_base + 1);
    check_frames(byte_base, burst_base);
    @(negedge clk);
    check_good_count();
endtask

task automatic loop_back_to_back();
    int byte_base;
    int burst_base;
    byte_base = tx_bytes.size();
    burst_base = burst_len.size();
    exp_bytes.delete();
    exp_lens.delete();
    make_frame(20);
    expect_frame();
    drive_frame(-1);
    // Second idle cycle on dv
    @(negedge clk);
    make_frame(24);
    expect_frame();
    drive_frame(-1);
    exp_count = exp_count + 2'd2;
    wait_bursts(burst_base + 2);
    check_frames(byte_base, burst_base);
    if (idle_len.size() > burst_base + 1) begin
        if (idle_len[burst_base + 1] < port_ctrl_pkg::IFG_CYCLES) begin
            report_mismatch($sformatf("gap between frames is %0d cycles, minimum %0d",
                idle_len[burst_base + 1], port_ctrl_pkg::IFG_CYCLES));
        end
    end
    @(negedge clk);
    check_good_count();
endtask

initial begin
    rst = 1'b1;
    uart_rxd = 1'b1;
    prescale = (port_ctrl_pkg::PRESCALE_W)'(BIT_CYCLES);
    gmii_rxd = 8'h00;
    gmii_rx_dv = 1'b0;
    gmii_rx_er = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);

    if (led !== 8'h00 || uart_txd !== 1'b1 || gmii_tx_en !== 1'b0) begin
        report_mismatch($sformatf("after reset led %02h txd %b tx_en %b, expected 00 1 0",
            led, uart_txd, gmii_tx_en));
    end

    echo_uart_bytes();
    flag_uart_stop_error();
    loop_good_frame();
    reject_bad_frame();
    reject_oversize_frame();
    loop_back_to_back();

    $display("Mismatches: %0d, other errors: %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
        $display("Finished with no errors");
    end else begin
        $display("Finished with errors");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== fpga_loop.f ====
hdl/stream_pkg.sv
hdl/port_ctrl_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/gmii_rx_adapter.sv
hdl/frame_fifo.sv
hdl/gmii_tx_framer.sv
hdl/fpga_core.sv
sim/tb_fpga_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the FPGA core testbench with Verilator

verilator --binary --timing --assert -Wno-fatal --top-module tb_fpga_core \
    -f fpga_loop.f --Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vtb_fpga_core > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log \
    && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation PASSED"; exit 0; }
